// File: Makefile
# Verilator simulation of the game state serial link.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_game_link \
		-f sim.f -o sim_tb_game_link
	./obj_dir/sim_tb_game_link > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "All tests passed!" $(LOG) || { echo "Simulation FAILED"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_game_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_link
    import game_pkg::*;
;

    localparam int BIT_CLKS      = 8;
    localparam int FRAME_BYTES   = 15;
    localparam int START_TIMEOUT = 40 * BIT_CLKS;
    localparam int SEED          = 34514;

    logic        clk;
    logic        rst;
    game_state_t state;
    logic        txd;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    game_link_top #(
        .CLKS_PER_BIT (BIT_CLKS),
        .FIFO_DEPTH   (16)
    ) dut (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .txd   (txd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected 0x%02h got 0x%02h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_result(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED", name);
        end
    endtask

    // Inputs change 1 ns after the rising edge.
    task automatic apply_state(input game_state_t s);
        @(posedge clk);
        #1;
        state = s;
    endtask

    // Byte layout of one frame, as seen by the host.
    function automatic logic [7:0] expected_byte(input game_state_t s, input int i);
        case (i)
            0:       return 8'h44;
            1:       return s.player.x[7:0];
            2:       return {4'h0, s.player.x[11:8]};
            3:       return s.player.y[7:0];
            4:       return {4'h0, s.player.y[11:8]};
            5:       return {4'h0, s.player.hp};
            6:       return {4'h0, s.player.aggro};
            7:       return {7'h00, s.player.flip_h};
            8:       return {6'h00, s.player.char_class};
            9:       return 8'h42;
            10:      return s.boss.x[7:0];
            11:      return {4'h0, s.boss.x[11:8]};
            12:      return s.boss.y[7:0];
            13:      return {4'h0, s.boss.y[11:8]};
            default: return {1'b0, s.boss.hp};
        endcase
    endfunction

    function automatic string byte_name(input int i);
        string names [FRAME_BYTES] = '{
            "player tag", "player x lo", "player x hi", "player y lo", "player y hi",
            "player hp", "player aggro", "player flip_h", "player class", "boss tag",
            "boss x lo", "boss x hi", "boss y lo", "boss y hi", "boss hp"
        };
        return names[i];
    endfunction

    // Samples on the falling clock edge, half a cycle away from txd updates.
    task automatic recv_byte(output logic [7:0] data, output logic ok);
        int waited;
        ok = 1'b0;
        data = 8'h00;
        waited = 0;
        @(negedge clk);
        while (txd !== 1'b1 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        while (txd !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            $display("ERROR at %0t: no start bit on txd within %0d cycles",
                     $time, START_TIMEOUT);
            errors++;
            return;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            $display("ERROR at %0t: start bit on txd ended too early", $time);
            errors++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = txd;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (txd !== 1'b1) begin
            $display("ERROR at %0t: stop bit on txd was low", $time);
            errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic expect_frame(input game_state_t s);
        logic [7:0] exp_bytes [FRAME_BYTES];
        logic [7:0] got;
        logic       ok;
        for (int i = 0; i < FRAME_BYTES; i++) begin
            exp_bytes[i] = expected_byte(s, i);
        end
        for (int i = 0; i < FRAME_BYTES; i++) begin
            recv_byte(got, ok);
            if (!ok) begin
                $display("ERROR at %0t: frame broken off at byte %0d", $time, i);
                break;
            end
            check_value(byte_name(i), exp_bytes[i], got);
        end
    endtask

    task automatic check_line_idle(input int bit_times);
        for (int i = 0; i < bit_times * BIT_CLKS; i++) begin
            @(negedge clk);
            if (txd !== 1'b1) begin
                $display("ERROR at %0t: start bit on txd while no frame was due", $time);
                errors++;
                break;
            end
        end
    endtask

    function automatic game_state_t random_state();
        game_state_t s;
        s.player.x          = 12'($urandom);
        s.player.y          = 12'($urandom);
        s.player.hp         = 4'($urandom);
        s.player.aggro      = 4'($urandom);
        s.player.flip_h     = 1'($urandom);
        s.player.char_class = 2'($urandom);
        s.boss.x            = 12'($urandom);
        s.boss.y            = 12'($urandom);
        s.boss.hp           = 7'($urandom);
        return s;
    endfunction

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        check_line_idle(40);
        report_result("idle_after_reset", e0);
    endtask

    task automatic single_change();
        game_state_t s;
        int          e0;
        e0 = errors;
        s.player = '{x: 12'hA5C, y: 12'h3F1, hp: 4'hB, aggro: 4'h6,
                     flip_h: 1'b1, char_class: 2'd2};
        s.boss   = '{x: 12'h7E2, y: 12'h109, hp: 7'h5A};
        apply_state(s);
        expect_frame(s);
        check_line_idle(40);
        report_result("single_change", e0);
    endtask

    task automatic single_field_changes();
        game_state_t s;
        int          e0;
        e0 = errors;
        s = state;
        s.boss.hp = s.boss.hp + 7'd17;
        apply_state(s);
        expect_frame(s);
        s.player.flip_h = ~s.player.flip_h;
        apply_state(s);
        expect_frame(s);
        check_line_idle(40);
        report_result("single_field_changes", e0);
    endtask

    // The second state arrives while the encoder still writes the first frame.
    // Its frame then backs up behind the first one until the FIFO is full.
    task automatic change_during_frame();
        game_state_t s1;
        game_state_t s2;
        int          e0;
        e0 = errors;
        s1.player = '{x: 12'h123, y: 12'hFED, hp: 4'h3, aggro: 4'hC,
                      flip_h: 1'b0, char_class: 2'd1};
        s1.boss   = '{x: 12'h0F0, y: 12'hABC, hp: 7'h7F};
        s2.player = '{x: 12'h800, y: 12'h00F, hp: 4'hF, aggro: 4'h1,
                      flip_h: 1'b1, char_class: 2'd3};
        s2.boss   = '{x: 12'hFFF, y: 12'h001, hp: 7'h01};
        apply_state(s1);
        apply_state(s2);
        expect_frame(s1);
        expect_frame(s2);
        check_line_idle(40);
        report_result("change_during_frame", e0);
    endtask

    task automatic random_states();
        game_state_t s;
        int          e0;
        e0 = errors;
        for (int n = 0; n < 10; n++) begin
            s = random_state();
            if (s == state) begin
                s.boss.hp = s.boss.hp ^ 7'd1;
            end
            apply_state(s);
            expect_frame(s);
        end
        check_line_idle(40);
        report_result("random_states", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        state = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_after_reset();
        single_change();
        single_field_changes();
        change_during_frame();
        random_states();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: common/game_pkg.sv
`default_nettype none

package game_pkg;

    // Player state as sampled from the game logic.
    // Positions are in screen pixels, the rest are small counters and flags.
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [3:0]  hp;
        logic [3:0]  aggro;
        logic        flip_h;
        logic [1:0]  char_class;
    } player_state_t;

    // Boss state.
    // Boss hp is wider than the player's, up to 127.
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [6:0]  hp;
    } boss_state_t;

    // Whole game state seen by the link.
    // The encoder compares this as one vector against its snapshot.
    typedef struct packed {
        player_state_t player;
        boss_state_t   boss;
    } game_state_t;

endpackage

`default_nettype wire

// File: common/link_pkg.sv
`default_nettype none

package link_pkg;

    // One byte on the serial line.
    typedef logic [7:0] link_byte_t;

    // Position of a byte within a frame.
    typedef logic [3:0] frame_idx_t;

    localparam int FRAME_LEN = 15;

    // Frame tags, ASCII "D" and "B".
    localparam link_byte_t PLAYER_TAG = 8'h44;
    localparam link_byte_t BOSS_TAG   = 8'h42;

    // Byte positions in a frame.
    localparam frame_idx_t IDX_TAG_P   = 4'd0;
    localparam frame_idx_t IDX_PX_LO   = 4'd1;
    localparam frame_idx_t IDX_PX_HI   = 4'd2;
    localparam frame_idx_t IDX_PY_LO   = 4'd3;
    localparam frame_idx_t IDX_PY_HI   = 4'd4;
    localparam frame_idx_t IDX_P_HP    = 4'd5;
    localparam frame_idx_t IDX_P_AGGRO = 4'd6;
    localparam frame_idx_t IDX_P_FLIP  = 4'd7;
    localparam frame_idx_t IDX_P_CLASS = 4'd8;
    localparam frame_idx_t IDX_TAG_B   = 4'd9;
    localparam frame_idx_t IDX_BX_LO   = 4'd10;
    localparam frame_idx_t IDX_BX_HI   = 4'd11;
    localparam frame_idx_t IDX_BY_LO   = 4'd12;
    localparam frame_idx_t IDX_BY_HI   = 4'd13;
    localparam frame_idx_t IDX_B_HP    = 4'd14;

endpackage

`default_nettype wire

// File: encoder/state_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module state_encoder
    import game_pkg::*, link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  logic        full,
    output link_byte_t  wr_data,
    output logic        wr
);

    typedef enum logic {
        IDLE,
        SENDING
    } enc_state_t;

    enc_state_t  enc_state;
    game_state_t snap;
    frame_idx_t  idx;
    logic        changed;
    logic        last_byte;

    assign changed   = (state != snap);
    assign last_byte = (idx == frame_idx_t'(FRAME_LEN - 1));

    // One byte per cycle while there is room in the FIFO.
    assign wr = (enc_state == SENDING) && !full;

    // Frame bytes come from the snapshot only, never from the live state.
    always_comb begin
        case (idx)
            IDX_TAG_P:   wr_data = PLAYER_TAG;
            IDX_PX_LO:   wr_data = snap.player.x[7:0];
            IDX_PX_HI:   wr_data = {4'd0, snap.player.x[11:8]};
            IDX_PY_LO:   wr_data = snap.player.y[7:0];
            IDX_PY_HI:   wr_data = {4'd0, snap.player.y[11:8]};
            IDX_P_HP:    wr_data = {4'd0, snap.player.hp};
            IDX_P_AGGRO: wr_data = {4'd0, snap.player.aggro};
            IDX_P_FLIP:  wr_data = {7'd0, snap.player.flip_h};
            IDX_P_CLASS: wr_data = {6'd0, snap.player.char_class};
            IDX_TAG_B:   wr_data = BOSS_TAG;
            IDX_BX_LO:   wr_data = snap.boss.x[7:0];
            IDX_BX_HI:   wr_data = {4'd0, snap.boss.x[11:8]};
            IDX_BY_LO:   wr_data = snap.boss.y[7:0];
            IDX_BY_HI:   wr_data = {4'd0, snap.boss.y[11:8]};
            IDX_B_HP:    wr_data = {1'b0, snap.boss.hp};
            default:     wr_data = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enc_state <= IDLE;
            snap      <= '0;
            idx       <= '0;
        end else begin
            case (enc_state)
                IDLE: begin
                    if (changed) begin
                        snap      <= state;
                        idx       <= '0;
                        enc_state <= SENDING;
                    end
                end
                SENDING: begin
                    // Hold the index while the FIFO is full.
                    if (!full) begin
                        if (last_byte) begin
                            idx       <= '0;
                            enc_state <= IDLE;
                        end else begin
                            idx <= idx + 4'd1;
                        end
                    end
                end
                default: enc_state <= IDLE;
            endcase
        end
    end

    a_idx_in_range : assert property (
        @(posedge clk) disable iff (rst) idx < frame_idx_t'(FRAME_LEN)
    ) else $error("frame index out of range");

endmodule

`default_nettype wire

// File: rtl/game_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_link_top
    import game_pkg::*, link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    output logic        txd
);

    link_byte_t wr_data;
    logic       wr;
    logic       full;
    link_byte_t rd_data;
    logic       rd;
    logic       empty;

    state_encoder u_encoder (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .full    (full),
        .wr_data (wr_data),
        .wr      (wr)
    );

    tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .wr_data (wr_data),
        .full    (full),
        .rd      (rd),
        .rd_data (rd_data),
        .empty   (empty)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk     (clk),
        .rst     (rst),
        .empty   (empty),
        .rd_data (rd_data),
        .rd      (rd),
        .txd     (txd)
    );

endmodule

`default_nettype wire

// File: sim.f
common/game_pkg.sv
common/link_pkg.sv
encoder/state_encoder.sv
uart_tx/tx_fifo.sv
uart_tx/uart_tx.sv
rtl/game_link_top.sv
bench/tb_game_link.sv

// File: uart_tx/tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tx_fifo
    import link_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  link_byte_t wr_data,
    output logic       full,
    input  logic       rd,
    output link_byte_t rd_data,
    output logic       empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    link_byte_t   mem [FIFO_DEPTH];
    logic [AW:0]  wr_ptr;
    logic [AW:0]  rd_ptr;

    // Pointers carry one extra wrap bit to tell full from empty.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Show-ahead: the head byte is always on rd_data.
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst) wr |-> !full
    ) else $error("FIFO write while full");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (rst) rd |-> !empty
    ) else $error("FIFO read while empty");

endmodule

`default_nettype wire

// File: uart_tx/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       empty,
    input  link_byte_t rd_data,
    output logic       rd,
    output logic       txd
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    tx_state_t        tx_state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    link_byte_t       shreg;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // Take the head byte as soon as the line is free.
    assign rd = (tx_state == IDLE) && !empty;

    // Shift register, LSB goes out first.
    always_ff @(posedge clk) begin
        if (rd) begin
            shreg <= rd_data;
        end else if (tx_state == DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_state <= IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (tx_state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!empty) begin
                        tx_state <= START;
                        txd      <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        tx_state <= DATA;
                        bit_cnt  <= '0;
                        txd      <= shreg[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            tx_state <= STOP;
                            txd      <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                            txd     <= shreg[1];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        tx_state <= IDLE;
                    end
                end
                default: tx_state <= IDLE;
            endcase
        end
    end

    a_idle_line_high : assert property (
        @(posedge clk) disable iff (rst) (tx_state == IDLE) |-> txd
    ) else $error("txd low while transmitter idle");

endmodule

`default_nettype wire
